/* files.f */
logic/divPkg.sv
logic/operandPrep.sv
logic/quotientSelect.sv
logic/srtIterator.sv
logic/otfConverter.sv
logic/resultFix.sv
logic/divUnit.sv
test/divChecker.sv
test/divUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the divider regression with Verilator

cd "$(dirname "$0")" || exit 1

mkdir -p build
if [ $? -ne 0 ]; then
    echo "cannot create the build directory"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal --top-module divUnitTb \
    -Mdir build -f files.f > build/compile.log 2>&1
if [ $? -ne 0 ]; then
    cat build/compile.log
    echo "compile failed, see build/compile.log"
    exit 1
fi

./build/VdivUnitTb > build/sim.log 2>&1
simStatus=$?
cat build/sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Regression passed" build/sim.log; then
    exit 0
fi
exit 1

/* test/divUnitTb.sv */
`timescale 1ns/1ps

module divUnitTb;

    localparam int DataWidth   = 32;
    localparam int NumDirected = 23;
    localparam int NumRandom   = 20;
    localparam int NumRows     = NumDirected + NumRandom;
    // a result takes at most 20 cycles after acceptance
    localparam int TimeoutCycles = NumRows * 25 + 20;

    typedef struct packed {
        divPkg::divOp_t       op;
        divPkg::regAddr_t     dest;
        logic [DataWidth-1:0] dividend;
        logic [DataWidth-1:0] divisor;
        logic                 pokeBusy;
    } stimRow_t;

    logic                 Clk;
    logic                 rstN;
    logic                 divValid;
    divPkg::divTag_t      tag;
    logic [DataWidth-1:0] dividend;
    logic [DataWidth-1:0] divisor;
    logic                 wbValid;
    divPkg::regAddr_t     wbDest;
    logic [DataWidth-1:0] wbData;
    int                   testCount;
    int                   errorCount;
    int                   cycleCount = 0;
    int                   seed = 32'h2d7dd8ca;
    stimRow_t             rows [NumRows];

    divUnit #(.DataWidth(DataWidth)) dut (
        .Clk     (Clk),
        .rstN    (rstN),
        .divValid(divValid),
        .tag     (tag),
        .dividend(dividend),
        .divisor (divisor),
        .wbValid (wbValid),
        .wbDest  (wbDest),
        .wbData  (wbData)
    );

    divChecker #(.DataWidth(DataWidth)) resultCheck (
        .Clk     (Clk),
        .rstN    (rstN),
        .divValid(divValid),
        .tag     (tag),
        .dividend(dividend),
        .divisor (divisor),
        .wbValid (wbValid),
        .wbDest  (wbDest),
        .wbData  (wbData),
        .tests   (testCount),
        .errors  (errorCount)
    );

    always #20 Clk = ~Clk;

    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout: run stopped after %0d cycles, the divider seems stuck",
                     cycleCount);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic stimRow_t makeRow(divPkg::divOp_t op, divPkg::regAddr_t dest,
                                         logic [DataWidth-1:0] a, logic [DataWidth-1:0] b,
                                         logic poke);
        stimRow_t row;
        row.op       = op;
        row.dest     = dest;
        row.dividend = a;
        row.divisor  = b;
        row.pokeBusy = poke;
        return row;
    endfunction

    task automatic fillRandomRows();
        logic [31:0]          r;
        logic [DataWidth-1:0] b;
        for (int i = NumDirected; i < NumRows; i++) begin
            r = $random(seed);
            rows[i].op       = divPkg::divOp_t'(r[1:0]);
            rows[i].dest     = r[6:2];
            rows[i].dividend = $random(seed);
            // a random shift spreads the divisors over all normalization amounts
            b = $random(seed);
            r = $random(seed);
            b = b >> r[4:0];
            rows[i].divisor  = (b == '0) ? 1 : b;
            rows[i].pokeBusy = 1'b0;
        end
    endtask

    // called on a falling edge, returns on the falling edge that sees wbValid
    task automatic runRow(input stimRow_t row);
        int waited;
        divValid      = 1'b1;
        tag.op        = row.op;
        tag.dest      = row.dest;
        dividend      = row.dividend;
        divisor       = row.divisor;
        waited        = 0;
        do begin
            @(negedge Clk);
            waited++;
            if (waited == 1) begin
                divValid = 1'b0;
            end
            // a second request while busy must be dropped
            if (row.pokeBusy && waited == 2) begin
                divValid = 1'b1;
                tag.dest = ~row.dest;
                dividend = ~row.dividend;
                divisor  = 3;
            end
            if (waited == 3) begin
                divValid = 1'b0;
            end
        end while (!wbValid);
        divValid = 1'b0;
    endtask

    initial begin
        Clk      = 1'b0;
        rstN     = 1'b0;
        divValid = 1'b0;
        tag      = '0;
        dividend = '0;
        divisor  = 1;
        rows[0]  = makeRow(divPkg::opDivwu, 5'd1, 32'd100, 32'd7, 1'b0);
        rows[1]  = makeRow(divPkg::opModwu, 5'd2, 32'd100, 32'd7, 1'b0);
        rows[2]  = makeRow(divPkg::opDivwu, 5'd3, 32'd5, 32'd9, 1'b0);
        rows[3]  = makeRow(divPkg::opModwu, 5'd4, 32'd5, 32'd9, 1'b0);
        rows[4]  = makeRow(divPkg::opDivwu, 5'd5, 32'hdeadbeef, 32'd1, 1'b0);
        rows[5]  = makeRow(divPkg::opModwu, 5'd6, 32'hdeadbeef, 32'd1, 1'b0);
        rows[6]  = makeRow(divPkg::opDivwu, 5'd7, 32'hffffffff, 32'hffffffff, 1'b0);
        rows[7]  = makeRow(divPkg::opModwu, 5'd8, 32'hffffffff, 32'd3, 1'b0);
        rows[8]  = makeRow(divPkg::opDivwu, 5'd9, 32'hffffffff, 32'h00010000, 1'b0);
        rows[9]  = makeRow(divPkg::opDivw, 5'd10, 32'd100, 32'd7, 1'b0);
        rows[10] = makeRow(divPkg::opDivw, 5'd11, -32'sd100, 32'd7, 1'b0);
        rows[11] = makeRow(divPkg::opModw, 5'd12, 32'd100, -32'sd7, 1'b0);
        rows[12] = makeRow(divPkg::opModw, 5'd13, -32'sd100, -32'sd7, 1'b0);
        rows[13] = makeRow(divPkg::opDivw, 5'd14, -32'sd100, -32'sd7, 1'b0);
        rows[14] = makeRow(divPkg::opModw, 5'd15, -32'sd100, 32'd7, 1'b0);
        rows[15] = makeRow(divPkg::opDivw, 5'd16, 32'h80000000, 32'hffffffff, 1'b0);
        rows[16] = makeRow(divPkg::opModw, 5'd17, 32'h80000000, 32'hffffffff, 1'b0);
        rows[17] = makeRow(divPkg::opDivw, 5'd18, 32'h7fffffff, 32'h80000000, 1'b0);
        rows[18] = makeRow(divPkg::opModw, 5'd19, 32'h7fffffff, 32'h80000000, 1'b0);
        rows[19] = makeRow(divPkg::opDivwu, 5'd20, 32'h12345678, 32'h00000abc, 1'b1);
        rows[20] = makeRow(divPkg::opModw, 5'd21, -32'sd12345, 32'd100, 1'b1);
        rows[21] = makeRow(divPkg::opDivw, 5'd22, 32'd100, -32'sd7, 1'b0);
        rows[22] = makeRow(divPkg::opModw, 5'd23, 32'd100, 32'd7, 1'b0);
        fillRandomRows();
        repeat (4) @(negedge Clk);
        rstN = 1'b1;
        repeat (3) @(negedge Clk);
        foreach (rows[i]) begin
            runRow(rows[i]);
        end
        // idle tail catches any stray write-back
        repeat (30) @(negedge Clk);
        $display("tests %0d, errors %0d", testCount, errorCount);
        if (testCount != NumRows) begin
            $display("result count wrong: %0d requests issued but %0d results seen",
                     NumRows, testCount);
        end
        if (errorCount == 0 && testCount == NumRows) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* test/divChecker.sv */
`timescale 1ns/1ps

module divChecker #(
    parameter int DataWidth = 32
) (
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic                 divValid,
    input  divPkg::divTag_t      tag,
    input  logic [DataWidth-1:0] dividend,
    input  logic [DataWidth-1:0] divisor,
    input  logic                 wbValid,
    input  divPkg::regAddr_t     wbDest,
    input  logic [DataWidth-1:0] wbData,
    output int                   tests,
    output int                   errors
);

    localparam logic [DataWidth-1:0] MinValue = {1'b1, {(DataWidth-1){1'b0}}};

    logic                 busy = 1'b0;
    divPkg::divTag_t      pendTag;
    logic [DataWidth-1:0] pendA;
    logic [DataWidth-1:0] pendB;
    int                   testCount = 0;
    int                   errorCount = 0;

    function automatic string opName(divPkg::divOp_t op);
        case (op)
            divPkg::opDivw:  return "divw ";
            divPkg::opDivwu: return "divwu";
            divPkg::opModw:  return "modw ";
            default:         return "modwu";
        endcase
    endfunction

    // truncating division, the remainder follows the dividend's sign
    function automatic logic [DataWidth-1:0] expectedValue(divPkg::divOp_t op,
                                                          logic [DataWidth-1:0] a,
                                                          logic [DataWidth-1:0] b);
        logic signed [DataWidth-1:0] sa;
        logic signed [DataWidth-1:0] sb;
        logic [DataWidth-1:0]        q;
        logic [DataWidth-1:0]        r;
        sa = a;
        sb = b;
        if (op == divPkg::opDivw || op == divPkg::opModw) begin
            if (a == MinValue && b == '1) begin
                q = a;
                r = '0;
            end else begin
                q = sa / sb;
                r = sa % sb;
            end
        end else begin
            q = a / b;
            r = a % b;
        end
        return (op == divPkg::opDivw || op == divPkg::opDivwu) ? q : r;
    endfunction

    // write-back is handled before a new request so back-to-back issue works
    always @(posedge Clk) begin : watch
        logic [DataWidth-1:0] expData;
        if (!rstN) begin
            busy = 1'b0;
        end else begin
            if (wbValid) begin
                if (!busy) begin
                    errorCount++;
                    $display("unexpected write-back to register %0d at %0t ns, no request pending",
                             wbDest, $time);
                end else begin
                    testCount++;
                    expData = expectedValue(pendTag.op, pendA, pendB);
                    if (wbData !== expData || wbDest !== pendTag.dest) begin
                        errorCount++;
                        $display("error at %0t ns: test %0d %s %h, %h gave x%0d = %h, expected x%0d = %h",
                                 $time, testCount, opName(pendTag.op), pendA, pendB,
                                 wbDest, wbData, pendTag.dest, expData);
                    end else begin
                        $display("test %0d %s %h, %h -> x%0d = %h ok", testCount,
                                 opName(pendTag.op), pendA, pendB, wbDest, wbData);
                    end
                    busy = 1'b0;
                end
            end
            if (divValid && !busy) begin
                pendTag = tag;
                pendA   = dividend;
                pendB   = divisor;
                busy    = 1'b1;
            end
        end
    end

    assign tests  = testCount;
    assign errors = errorCount;

endmodule

/* logic/divUnit.sv */
`timescale 1ns/1ps

module divUnit #(
    parameter int DataWidth = 32
) (
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic                 divValid,
    input  divPkg::divTag_t      tag,
    input  logic [DataWidth-1:0] dividend,
    input  logic [DataWidth-1:0] divisor,
    output logic                 wbValid,
    output divPkg::regAddr_t     wbDest,
    output logic [DataWidth-1:0] wbData
);

    logic [DataWidth-1:0] normDivisor;
    logic [DataWidth+2:0] scaledDividend;
    divPkg::shiftAmt_t    steps;
    divPkg::shiftAmt_t    shift;
    logic                 quotNeg;
    logic                 remNeg;
    divPkg::qDigit_t      digit;
    logic                 digitValid;
    logic [DataWidth+5:0] remainder;
    logic [DataWidth-1:0] doneDivisor;
    divPkg::shiftAmt_t    doneShift;
    logic                 doneQuotNeg;
    logic                 doneRemNeg;
    divPkg::divTag_t      doneTag;
    logic                 done;
    logic [DataWidth-1:0] quotient;
    divPkg::regAddr_t     fixDest;
    logic [DataWidth-1:0] fixData;

    operandPrep #(.DataWidth(DataWidth)) prep (
        .dividend      (dividend),
        .divisor       (divisor),
        .op            (tag.op),
        .normDivisor   (normDivisor),
        .scaledDividend(scaledDividend),
        .steps         (steps),
        .shift         (shift),
        .quotNeg       (quotNeg),
        .remNeg        (remNeg)
    );

    srtIterator #(.DataWidth(DataWidth)) iter (
        .Clk           (Clk),
        .rstN          (rstN),
        .start         (divValid),
        .tag           (tag),
        .normDivisor   (normDivisor),
        .scaledDividend(scaledDividend),
        .steps         (steps),
        .shift         (shift),
        .quotNeg       (quotNeg),
        .remNeg        (remNeg),
        .digit         (digit),
        .digitValid    (digitValid),
        .remainder     (remainder),
        .doneDivisor   (doneDivisor),
        .doneShift     (doneShift),
        .doneQuotNeg   (doneQuotNeg),
        .doneRemNeg    (doneRemNeg),
        .doneTag       (doneTag),
        .done          (done)
    );

    // the converter empties after each result so it starts clean on the next request
    otfConverter #(.DataWidth(DataWidth)) otf (
        .Clk       (Clk),
        .rstN      (rstN),
        .clear     (done),
        .digitValid(digitValid),
        .digit     (digit),
        .quotient  (quotient)
    );

    resultFix #(.DataWidth(DataWidth)) fix (
        .remainder  (remainder),
        .normDivisor(doneDivisor),
        .shift      (doneShift),
        .quotient   (quotient),
        .quotNeg    (doneQuotNeg),
        .remNeg     (doneRemNeg),
        .tag        (doneTag),
        .wbDest     (fixDest),
        .wbData     (fixData)
    );

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= done;
        end
    end

    always_ff @(posedge Clk) begin
        if (done) begin
            wbDest <= fixDest;
            wbData <= fixData;
        end
    end

    // divide by zero is not handled by the datapath
    noZeroDivisor: assert property (@(posedge Clk) disable iff (!rstN)
        divValid |-> (divisor != '0));

endmodule

/* logic/resultFix.sv */
`timescale 1ns/1ps

module resultFix #(
    parameter int DataWidth = 32,
    localparam int RemWidth = DataWidth + 6
) (
    input  logic [RemWidth-1:0]  remainder,
    input  logic [DataWidth-1:0] normDivisor,
    input  divPkg::shiftAmt_t    shift,
    input  logic [DataWidth-1:0] quotient,
    input  logic                 quotNeg,
    input  logic                 remNeg,
    input  divPkg::divTag_t      tag,
    output divPkg::regAddr_t     wbDest,
    output logic [DataWidth-1:0] wbData
);

    logic                 remNegative;
    logic [RemWidth-1:0]  remFix;
    logic [DataWidth-1:0] quotFix;
    logic [DataWidth-1:0] remAbs;
    logic [DataWidth-1:0] quotOut;
    logic [DataWidth-1:0] remOut;

    // a negative final remainder means the last digit overshot by one
    assign remNegative = remainder[RemWidth-1];
    assign remFix  = remNegative ? (remainder + {3'b000, normDivisor, 3'b000}) : remainder;
    assign quotFix = remNegative ? (quotient - 1'b1) : quotient;

    // undo the fraction alignment and the divisor normalization
    assign remAbs = DataWidth'(remFix >> (shift + 6'd3));

    // min / -1 falls out of the two's complement wrap
    assign quotOut = quotNeg ? (~quotFix + 1'b1) : quotFix;
    assign remOut  = remNeg ? (~remAbs + 1'b1) : remAbs;

    assign wbData = divPkg::isQuotientOp(tag.op) ? quotOut : remOut;
    assign wbDest = tag.dest;

endmodule

/* logic/otfConverter.sv */
`timescale 1ns/1ps

module otfConverter #(
    parameter int DataWidth = 32
) (
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic                 clear,
    input  logic                 digitValid,
    input  divPkg::qDigit_t      digit,
    output logic [DataWidth-1:0] quotient
);

    // qReg holds Q, qmReg holds Q-1, both modulo 2^DataWidth
    logic [DataWidth-1:0] qReg;
    logic [DataWidth-1:0] qmReg;

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            qReg  <= '0;
            qmReg <= '1;
        end else if (clear) begin
            qReg  <= '0;
            qmReg <= '1;
        end else if (digitValid) begin
            case (digit)
                divPkg::qPos2: begin
                    qReg  <= {qReg[DataWidth-3:0], 2'b10};
                    qmReg <= {qReg[DataWidth-3:0], 2'b01};
                end
                divPkg::qPos1: begin
                    qReg  <= {qReg[DataWidth-3:0], 2'b01};
                    qmReg <= {qReg[DataWidth-3:0], 2'b00};
                end
                divPkg::qZero: begin
                    qReg  <= {qReg[DataWidth-3:0], 2'b00};
                    qmReg <= {qmReg[DataWidth-3:0], 2'b11};
                end
                // negative digits borrow from Q-1 instead of rippling a carry
                divPkg::qNeg1: begin
                    qReg  <= {qmReg[DataWidth-3:0], 2'b11};
                    qmReg <= {qmReg[DataWidth-3:0], 2'b10};
                end
                divPkg::qNeg2: begin
                    qReg  <= {qmReg[DataWidth-3:0], 2'b10};
                    qmReg <= {qmReg[DataWidth-3:0], 2'b01};
                end
                default: begin
                    qReg  <= qReg;
                    qmReg <= qmReg;
                end
            endcase
        end
    end

    assign quotient = qReg;

endmodule

/* logic/srtIterator.sv */
`timescale 1ns/1ps

module srtIterator #(
    parameter int DataWidth = 32,
    localparam int RemWidth = DataWidth + 6
) (
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic                 start,
    input  divPkg::divTag_t      tag,
    input  logic [DataWidth-1:0] normDivisor,
    input  logic [DataWidth+2:0] scaledDividend,
    input  divPkg::shiftAmt_t    steps,
    input  divPkg::shiftAmt_t    shift,
    input  logic                 quotNeg,
    input  logic                 remNeg,
    output divPkg::qDigit_t      digit,
    output logic                 digitValid,
    output logic [RemWidth-1:0]  remainder,
    output logic [DataWidth-1:0] doneDivisor,
    output divPkg::shiftAmt_t    doneShift,
    output logic                 doneQuotNeg,
    output logic                 doneRemNeg,
    output divPkg::divTag_t      doneTag,
    output logic                 done
);

    localparam int MaxSteps = DataWidth / 2 + 1;

    divPkg::divState_t    state;
    divPkg::shiftAmt_t    stepCnt;
    logic                 accept;

    // partial remainder, 3 integer bits and DataWidth+3 fraction bits
    logic [RemWidth-1:0]  remReg;
    logic [RemWidth-1:0]  remShifted;
    logic [RemWidth-1:0]  remNext;
    logic [RemWidth-1:0]  divTimes1;
    logic [RemWidth-1:0]  divTimes2;
    logic [DataWidth-1:0] divReg;
    logic signed [6:0]    estimate;
    logic signed [5:0]    remTop;
    logic [3:0]           divisorTop;

    assign accept     = start && (state == divPkg::sIdle);
    assign digitValid = (state == divPkg::sIterate) && (stepCnt != 6'd0);
    assign done       = (state == divPkg::sFinish);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state   <= divPkg::sIdle;
            stepCnt <= '0;
        end else begin
            case (state)
                divPkg::sIdle: begin
                    if (accept) begin
                        state   <= divPkg::sIterate;
                        stepCnt <= steps;
                    end
                end
                // one extra cycle once the count runs out, then finish
                divPkg::sIterate: begin
                    if (stepCnt != 6'd0) begin
                        stepCnt <= stepCnt - 6'd1;
                    end else begin
                        state <= divPkg::sFinish;
                    end
                end
                default: state <= divPkg::sIdle;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            remReg      <= {3'b000, scaledDividend};
            divReg      <= normDivisor;
            doneShift   <= shift;
            doneQuotNeg <= quotNeg;
            doneRemNeg  <= remNeg;
            doneTag     <= tag;
        end else if (digitValid) begin
            remReg <= remNext;
        end
    end

    assign remShifted = {remReg[RemWidth-3:0], 2'b00};
    assign divTimes1  = {3'b000, divReg, 3'b000};
    assign divTimes2  = {2'b00, divReg, 4'b0000};

    // 4w estimate with 4 fraction bits, saturated into the 6-bit table input
    assign estimate = remShifted[RemWidth-1 -: 7];

    always_comb begin
        if (estimate[6] != estimate[5]) begin
            remTop = estimate[6] ? 6'sb100000 : 6'sb011111;
        end else begin
            remTop = estimate[5:0];
        end
    end

    assign divisorTop = divReg[DataWidth-1 -: 4];

    quotientSelect qSel (
        .divisorTop(divisorTop),
        .remTop    (remTop),
        .digit     (digit)
    );

    always_comb begin
        case (digit)
            divPkg::qPos2: remNext = remShifted - divTimes2;
            divPkg::qPos1: remNext = remShifted - divTimes1;
            divPkg::qNeg1: remNext = remShifted + divTimes1;
            divPkg::qNeg2: remNext = remShifted + divTimes2;
            default:       remNext = remShifted;
        endcase
    end

    assign remainder   = remReg;
    assign doneDivisor = divReg;

    stepBound: assert property (@(posedge Clk) disable iff (!rstN)
        stepCnt <= divPkg::shiftAmt_t'(MaxSteps));

    // the table only covers divisors that operandPrep has normalized
    normalizedDivisor: assert property (@(posedge Clk) disable iff (!rstN)
        digitValid |-> divisorTop[3]);

endmodule

/* logic/quotientSelect.sv */
`timescale 1ns/1ps

module quotientSelect (
    input  logic [3:0]        divisorTop,
    input  logic signed [5:0] remTop,
    output divPkg::qDigit_t   digit
);

    // selection constants in units of 1/16, one set per divisor interval
    logic signed [5:0] mPos2;
    logic signed [5:0] mPos1;
    logic signed [5:0] mZero;
    logic signed [5:0] mNeg1;

    always_comb begin
        case (divisorTop)
            4'b1000: begin
                mPos2 = 6'sd12;
                mPos1 = 6'sd4;
                mZero = -6'sd4;
                mNeg1 = -6'sd13;
            end
            4'b1001: begin
                mPos2 = 6'sd14;
                mPos1 = 6'sd4;
                mZero = -6'sd6;
                mNeg1 = -6'sd15;
            end
            4'b1010: begin
                mPos2 = 6'sd15;
                mPos1 = 6'sd4;
                mZero = -6'sd6;
                mNeg1 = -6'sd16;
            end
            4'b1011: begin
                mPos2 = 6'sd16;
                mPos1 = 6'sd4;
                mZero = -6'sd6;
                mNeg1 = -6'sd18;
            end
            4'b1100: begin
                mPos2 = 6'sd18;
                mPos1 = 6'sd6;
                mZero = -6'sd8;
                mNeg1 = -6'sd20;
            end
            4'b1101: begin
                mPos2 = 6'sd20;
                mPos1 = 6'sd6;
                mZero = -6'sd8;
                mNeg1 = -6'sd20;
            end
            4'b1110: begin
                mPos2 = 6'sd20;
                mPos1 = 6'sd8;
                mZero = -6'sd8;
                mNeg1 = -6'sd22;
            end
            // 1111, a normalized divisor never shows a prefix below 1000
            default: begin
                mPos2 = 6'sd24;
                mPos1 = 6'sd8;
                mZero = -6'sd8;
                mNeg1 = -6'sd24;
            end
        endcase
    end

    always_comb begin
        if (remTop >= mPos2) begin
            digit = divPkg::qPos2;
        end else if (remTop >= mPos1) begin
            digit = divPkg::qPos1;
        end else if (remTop >= mZero) begin
            digit = divPkg::qZero;
        end else if (remTop >= mNeg1) begin
            digit = divPkg::qNeg1;
        end else begin
            digit = divPkg::qNeg2;
        end
    end

endmodule

/* logic/operandPrep.sv */
`timescale 1ns/1ps

module operandPrep #(
    parameter int DataWidth = 32
) (
    input  logic [DataWidth-1:0] dividend,
    input  logic [DataWidth-1:0] divisor,
    input  divPkg::divOp_t       op,
    output logic [DataWidth-1:0] normDivisor,
    output logic [DataWidth+2:0] scaledDividend,
    output divPkg::shiftAmt_t    steps,
    output divPkg::shiftAmt_t    shift,
    output logic                 quotNeg,
    output logic                 remNeg
);

    localparam int Groups = DataWidth / 4;

    logic                 dividendNeg;
    logic                 divisorNeg;
    logic [DataWidth-1:0] absDividend;
    logic [DataWidth-1:0] absDivisor;

    // leading zeros of a nonzero nibble
    function automatic divPkg::shiftAmt_t leadZeros4(input logic [3:0] nib);
        casez (nib)
            4'b1???: return 6'd0;
            4'b01??: return 6'd1;
            4'b001?: return 6'd2;
            default: return 6'd3;
        endcase
    endfunction

    // unsigned operations keep their operands as they are
    assign dividendNeg = divPkg::isSignedOp(op) && dividend[DataWidth-1];
    assign divisorNeg  = divPkg::isSignedOp(op) && divisor[DataWidth-1];

    assign absDividend = dividendNeg ? (~dividend + 1'b1) : dividend;
    assign absDivisor  = divisorNeg ? (~divisor + 1'b1) : divisor;

    assign quotNeg = dividendNeg ^ divisorNeg;
    assign remNeg  = dividendNeg;

    // scan nibbles from the bottom so the highest nonzero one decides
    always_comb begin
        shift = divPkg::shiftAmt_t'(DataWidth);
        for (int g = 0; g < Groups; g++) begin
            if (absDivisor[g*4 +: 4] != 4'b0000) begin
                shift = divPkg::shiftAmt_t'((Groups - 1 - g) * 4)
                      + leadZeros4(absDivisor[g*4 +: 4]);
            end
        end
    end

    assign normDivisor = absDivisor << shift;

    // remainder starts at x/4, or x/8 for an odd shift so the step count is whole
    assign scaledDividend = shift[0] ? {3'b000, absDividend} : {2'b00, absDividend, 1'b0};

    // ceil(shift/2) + 1 radix-4 digits
    assign steps = ((shift + 6'd1) >> 1) + 6'd1;

endmodule

/* logic/divPkg.sv */
package divPkg;

    // operation code carried with each request
    typedef enum logic [1:0] {
        opDivw  = 2'b00,
        opDivwu = 2'b01,
        opModw  = 2'b10,
        opModwu = 2'b11
    } divOp_t;

    typedef logic [4:0] regAddr_t;

    // travels with the request and comes back with the result
    typedef struct packed {
        divOp_t   op;
        regAddr_t dest;
    } divTag_t;

    // signed-digit code, the encoding reads as a 3-bit two's complement value
    typedef enum logic [2:0] {
        qPos2 = 3'b010,
        qPos1 = 3'b001,
        qZero = 3'b000,
        qNeg1 = 3'b111,
        qNeg2 = 3'b110
    } qDigit_t;

    typedef enum logic [1:0] {
        sIdle    = 2'b00,
        sIterate = 2'b01,
        sFinish  = 2'b10
    } divState_t;

    // normalization shift or remaining step count, 0 to 32
    typedef logic [5:0] shiftAmt_t;

    function automatic logic isSignedOp(divOp_t op);
        return (op == opDivw) || (op == opModw);
    endfunction

    function automatic logic isQuotientOp(divOp_t op);
        return (op == opDivw) || (op == opDivwu);
    endfunction

endpackage
